/* vga_top.f */
src/vga_pkg.sv
src/vga_apb_regs.sv
src/vga_timing_gen.sv
src/vga_channel_pattern.sv
src/vga_pixel_out.sv
src/vga_top.sv
dv/vga_tb.sv

/* run.sh */
#!/bin/sh
# compile the testbench and RTL, then run; exit status carries pass or fail
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module vga_tb -f vga_top.f -o vga_sim \
  && ./obj_dir/vga_sim \
  || { echo "simulation failed"; exit 1; }

/* dv/vga_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_tb;

  // small test mode, 25 cycles per line and 11 lines per frame
  localparam int small_frame = 25 * 11;
  // bars need x to reach 1023 so that all eight bars show
  localparam int bars_active = 1024;
  localparam int bars_frame = (9 + bars_active) * 11;
  // ramp widens the line to 40 pixels, checker also grows to 20 active lines
  localparam int ramp_frame = 49 * 11;
  localparam int checker_frame = 49 * 25;
  // frame budget of every video test, plus register traffic
  localparam int timeout_cycles = 8 * small_frame
                                + 3 * (bars_frame + ramp_frame + checker_frame) + 600;
  localparam int fall_limit = 2 * bars_frame;

  logic              clk_in = 1'b0;
  logic              rst;
  logic [7:0]        paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              hsync_n;
  logic              vsync_n;
  vga_pkg::vga_rgb_t rgb;

  // pin monitor state, sampled on the falling edge
  logic              hs_now;
  logic              vs_now;
  logic              hs_fell;
  logic              vs_fell;
  vga_pkg::vga_rgb_t rgb_now;
  int                h_pos;
  int                line_pos;

  // geometry currently programmed
  int hs_len;
  int vs_len;
  int ha_len;
  int va_len;
  int h_start;
  int v_start;
  int frame_len;

  int          cycle_count = 0;
  logic [7:0]  reg_addr [10] = '{
    vga_pkg::addr_h_sync, vga_pkg::addr_h_back, vga_pkg::addr_h_active, vga_pkg::addr_h_front,
    vga_pkg::addr_v_sync, vga_pkg::addr_v_back, vga_pkg::addr_v_active, vga_pkg::addr_v_front,
    vga_pkg::addr_color, vga_pkg::addr_ctrl
  };
  logic [31:0] reg_default [10] = '{96, 48, 640, 16, 2, 33, 480, 10, 0, 0};

  vga_top DUT (
    .clk_in  (clk_in),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .hsync_n (hsync_n),
    .vsync_n (vsync_n),
    .rgb     (rgb)
  );

  always #5 clk_in = ~clk_in;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  always @(posedge clk_in) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      abort_run($sformatf("timeout, the run did not finish in %0d cycles", timeout_cycles));
    end
  end

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                          name, expected, actual));
    end
  endtask

  task automatic apb_access(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waits;
    waits = 0;
    @(negedge clk_in);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk_in);
    penable = 1'b1;
    #1;
    while (pready !== 1'b1) begin
      @(negedge clk_in);
      #1;
      waits++;
      if (waits > 16) begin
        abort_run("APB access never completed, pready stayed low");
      end
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk_in);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(addr, 1'b1, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(addr, 1'b0, 32'h0, data, err);
  endtask

  task automatic write_reg(input string name, input logic [7:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_eq({name, " pslverr"}, 32'd0, {31'd0, err});
  endtask

  task automatic read_reg(input string name, input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    check_eq({name, " pslverr"}, 32'd0, {31'd0, err});
  endtask

  // pick up the pins again after cycles spent on bus traffic
  task automatic resync_monitor();
    @(negedge clk_in);
    hs_now  = hsync_n;
    vs_now  = vsync_n;
    rgb_now = rgb;
    hs_fell = 1'b0;
    vs_fell = 1'b0;
  endtask

  // h counts cycles since the hsync_n fall, lines count hsync_n falls since vsync_n fell
  task automatic sample_cycle();
    @(negedge clk_in);
    hs_fell = hs_now && !hsync_n;
    vs_fell = vs_now && !vsync_n;
    hs_now  = hsync_n;
    vs_now  = vsync_n;
    rgb_now = rgb;
    if (hs_fell) begin
      h_pos    = 0;
      line_pos = vs_fell ? 0 : line_pos + 1;
    end else begin
      h_pos++;
    end
  endtask

  task automatic wait_fall(input string name, input logic use_v);
    int n;
    n = 0;
    resync_monitor();
    while (use_v ? !vs_fell : !hs_fell) begin
      sample_cycle();
      n++;
      if (n > fall_limit) begin
        abort_run($sformatf("%s: no sync falling edge seen on the pins", name));
      end
    end
  endtask

  // starts on a falling edge, returns on the next one
  task automatic measure_pulse(input logic use_v, output int low_len, output int period);
    low_len = 0;
    period  = 0;
    do begin
      if (!(use_v ? vs_now : hs_now) && period == low_len) begin
        low_len++;
      end
      period++;
      sample_cycle();
      if (period > fall_limit) begin
        abort_run("sync pulse did not repeat");
      end
    end while (use_v ? !vs_fell : !hs_fell);
  endtask

  function automatic vga_pkg::vga_rgb_t expect_pixel(input int h, input int line,
                                                     input vga_pkg::vga_pattern_e pat,
                                                     input vga_pkg::vga_rgb_t col);
    int                x;
    int                y;
    logic [3:0]        lvl;
    logic [3:0]        val;
    vga_pkg::vga_rgb_t px;
    px = '0;
    x  = h - h_start;
    y  = line - v_start;
    if (x < 0 || x >= ha_len || y < 0 || y >= va_len) begin
      return px;
    end
    // lane 0 is blue, 1 green, 2 red
    for (int c = 0; c < 3; c++) begin
      lvl = (c == 0) ? col.b : ((c == 1) ? col.g : col.r);
      case (pat)
        vga_pkg::pat_solid: val = lvl;
        vga_pkg::pat_bars:  val = (((x >> vga_pkg::bar_shift) >> c) & 1) != 0 ? 4'hf : 4'h0;
        vga_pkg::pat_ramp:  val = 4'((x >> vga_pkg::check_bit) & 15);
        default: val = (((x ^ y) >> vga_pkg::check_bit) & 1) != 0 ? lvl : 4'h0;
      endcase
      if (c == 0) begin
        px.b = val;
      end else if (c == 1) begin
        px.g = val;
      end else begin
        px.r = val;
      end
    end
    return px;
  endfunction

  task automatic program_mode(input int h_active, input int v_active,
                              input vga_pkg::vga_pattern_e pat, input vga_pkg::vga_rgb_t col);
    logic [31:0] timing_val [8];
    timing_val = '{4, 3, h_active, 2, 2, 2, v_active, 1};
    hs_len    = 4;
    vs_len    = 2;
    ha_len    = h_active;
    va_len    = v_active;
    h_start   = 7;
    v_start   = 4;
    frame_len = (9 + h_active) * (5 + v_active);
    // park the generator so the new frame starts with the new geometry
    write_reg("disable", vga_pkg::addr_ctrl, 32'd0);
    for (int i = 0; i < 8; i++) begin
      write_reg("program timing", reg_addr[i], timing_val[i]);
    end
    write_reg("program color", vga_pkg::addr_color, {20'd0, col});
    write_reg("enable", vga_pkg::addr_ctrl, {29'd0, pat, 1'b1});
  endtask

  task automatic check_frames(input string name, input vga_pkg::vga_pattern_e pat,
                              input vga_pkg::vga_rgb_t col, input int nframes, output int lit);
    vga_pkg::vga_rgb_t px;
    lit = 0;
    wait_fall(name, 1'b1);
    for (int i = 0; i < nframes * frame_len; i++) begin
      if (i != 0) begin
        sample_cycle();
      end
      px = expect_pixel(h_pos, line_pos, pat, col);
      check_eq({name, " rgb"}, {20'd0, px}, {20'd0, rgb_now});
      check_eq({name, " hsync_n"}, {31'd0, h_pos >= hs_len}, {31'd0, hs_now});
      check_eq({name, " vsync_n"}, {31'd0, line_pos >= vs_len}, {31'd0, vs_now});
      if (rgb_now != '0) begin
        lit++;
      end
    end
  endtask

  task automatic test_reset_defaults();
    logic [31:0] rd;
    logic        err;
    for (int i = 0; i < 10; i++) begin
      read_reg($sformatf("default reg 0x%0h", reg_addr[i]), reg_addr[i], rd);
      check_eq($sformatf("default reg 0x%0h", reg_addr[i]), reg_default[i], rd);
    end
    read_reg("default frames", vga_pkg::addr_frames, rd);
    check_eq("default frames", 32'd0, rd);
    apb_read(8'h2C, rd, err);
    check_eq("unmapped read pslverr", 32'd1, {31'd0, err});
    apb_write(vga_pkg::addr_frames, 32'h1234, err);
    check_eq("frames write pslverr", 32'd1, {31'd0, err});
    read_reg("frames after write", vga_pkg::addr_frames, rd);
    check_eq("frames after write", 32'd0, rd);
    resync_monitor();
    for (int i = 0; i < 30; i++) begin
      sample_cycle();
      check_eq("disabled hsync_n", 32'd1, {31'd0, hs_now});
      check_eq("disabled vsync_n", 32'd1, {31'd0, vs_now});
      check_eq("disabled rgb", 32'd0, {20'd0, rgb_now});
    end
  endtask

  task automatic test_readback();
    logic [31:0] wd;
    logic [31:0] rd;
    logic [31:0] mask;
    for (int i = 0; i < 10; i++) begin
      wd = $urandom;
      // timing regs hold 11 bits, colour 12, control keeps enable off
      mask = (i < 8) ? 32'h7ff : ((i == 8) ? 32'hfff : 32'h6);
      write_reg("readback write", reg_addr[i], wd & ((i == 9) ? 32'h6 : 32'hffffffff));
      read_reg("readback read", reg_addr[i], rd);
      check_eq($sformatf("readback reg 0x%0h", reg_addr[i]), wd & mask, rd);
    end
  endtask

  task automatic test_sync_timing();
    int          low_len;
    int          period;
    logic [31:0] f0;
    logic [31:0] f1;
    program_mode(16, 6, vga_pkg::pat_solid, 12'h0);
    wait_fall("hsync timing", 1'b0);
    for (int i = 0; i < 3; i++) begin
      measure_pulse(1'b0, low_len, period);
      check_eq("hsync low cycles", 32'd4, low_len);
      check_eq("hsync period", 32'd25, period);
    end
    wait_fall("vsync timing", 1'b1);
    measure_pulse(1'b1, low_len, period);
    check_eq("vsync low cycles", 32'd2 * 25, low_len);
    check_eq("vsync period", small_frame, period);
    for (int i = 0; i < 2; i++) begin
      read_reg("frame count", vga_pkg::addr_frames, f0);
      wait_fall("frame count", 1'b1);
      read_reg("frame count", vga_pkg::addr_frames, f1);
      check_eq("frame count step", (f0 + 32'd1) & 32'hffff, f1);
    end
  endtask

  task automatic test_solid();
    vga_pkg::vga_rgb_t col;
    int                lit;
    col = vga_pkg::vga_rgb_t'(12'($urandom_range(4095, 1)));
    program_mode(16, 6, vga_pkg::pat_solid, col);
    check_frames("solid", vga_pkg::pat_solid, col, 1, lit);
    check_eq("solid lit pixels", 32'd16 * 6, lit);
  endtask

  task automatic test_patterns();
    vga_pkg::vga_rgb_t col;
    int                lit;
    col = vga_pkg::vga_rgb_t'(12'($urandom_range(4095, 1)));
    // full width line so every bar from black to white shows
    program_mode(bars_active, 6, vga_pkg::pat_bars, col);
    check_frames("bars", vga_pkg::pat_bars, col, 2, lit);
    // wider line so ramp steps and checker cells change across x
    program_mode(40, 6, vga_pkg::pat_ramp, col);
    check_frames("ramp", vga_pkg::pat_ramp, col, 2, lit);
    // taller window so checker cells also flip down y
    program_mode(40, 20, vga_pkg::pat_checker, col);
    check_frames("checker", vga_pkg::pat_checker, col, 2, lit);
  endtask

  task automatic test_mid_frame_change();
    int low_len;
    int period;
    int lines;
    program_mode(16, 6, vga_pkg::pat_solid, 12'h0);
    wait_fall("mid-frame", 1'b1);
    measure_pulse(1'b0, low_len, period);
    write_reg("mid-frame h_active", vga_pkg::addr_h_active, 32'd20);
    wait_fall("mid-frame", 1'b0);
    lines = 0;
    while (!vs_fell) begin
      measure_pulse(1'b0, low_len, period);
      check_eq("mid-frame old line period", 32'd25, period);
      lines++;
      if (lines > 12) begin
        abort_run("mid-frame: vsync_n did not fall after the timing change");
      end
    end
    measure_pulse(1'b0, low_len, period);
    check_eq("mid-frame new line period", 32'd29, period);
  endtask

  initial begin
    void'($urandom(32'h4a3399da));
    rst      = 1'b1;
    paddr    = 8'h0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = 32'h0;
    hs_now   = 1'b1;
    vs_now   = 1'b1;
    hs_fell  = 1'b0;
    vs_fell  = 1'b0;
    rgb_now  = '0;
    h_pos    = 0;
    line_pos = 0;
    repeat (3) @(negedge clk_in);
    rst = 1'b0;
    test_reset_defaults();
    test_readback();
    test_sync_timing();
    test_solid();
    test_patterns();
    test_mid_frame_change();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* src/vga_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_top (
  input  logic              clk_in,
  input  logic              rst,
  input  logic [7:0]        paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              hsync_n,
  output logic              vsync_n,
  output vga_pkg::vga_rgb_t rgb
);

  vga_pkg::vga_cfg_t    cfg;
  vga_pkg::vga_timing_t timing;
  logic                 frame_start;

  // lane index follows bit order of the packed colour, red on top
  logic [vga_pkg::num_chan-1:0][vga_pkg::chan_w-1:0] level;
  logic [vga_pkg::num_chan-1:0][vga_pkg::chan_w-1:0] intensity;

  assign level = {cfg.color.r, cfg.color.g, cfg.color.b};

  vga_apb_regs u_regs (
    .clk_in      (clk_in),
    .rst         (rst),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .frame_start (frame_start),
    .cfg         (cfg)
  );

  vga_timing_gen u_timing (
    .clk_in      (clk_in),
    .rst         (rst),
    .cfg         (cfg),
    .timing      (timing),
    .frame_start (frame_start)
  );

  for (genvar gi = 0; gi < vga_pkg::num_chan; gi++) begin : g_lane
    vga_channel_pattern #(
      .chan_idx (gi)
    ) u_lane (
      .clk_in    (clk_in),
      .rst       (rst),
      .timing    (timing),
      .pattern   (cfg.pattern),
      .level     (level[gi]),
      .intensity (intensity[gi])
    );
  end

  vga_pixel_out u_out (
    .clk_in    (clk_in),
    .rst       (rst),
    .timing    (timing),
    .intensity (intensity),
    .hsync_n   (hsync_n),
    .vsync_n   (vsync_n),
    .rgb       (rgb)
  );

endmodule

`default_nettype wire

/* src/vga_pixel_out.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_pixel_out (
  input  logic                                             clk_in,
  input  logic                                             rst,
  input  vga_pkg::vga_timing_t                             timing,
  input  logic [vga_pkg::num_chan-1:0][vga_pkg::chan_w-1:0] intensity,
  output logic                                             hsync_n,
  output logic                                             vsync_n,
  output vga_pkg::vga_rgb_t                                rgb
);

  // one stage to line up with the lane registers
  logic hsync_n_d;
  logic vsync_n_d;
  logic active_d;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      hsync_n_d <= 1'b1;
      vsync_n_d <= 1'b1;
      active_d  <= 1'b0;
    end else begin
      hsync_n_d <= timing.hsync_n;
      vsync_n_d <= timing.vsync_n;
      active_d  <= timing.active;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
      rgb     <= '0;
    end else begin
      hsync_n <= hsync_n_d;
      vsync_n <= vsync_n_d;
      // blank outside the visible window
      if (active_d) begin
        rgb <= '{r: intensity[2], g: intensity[1], b: intensity[0]};
      end else begin
        rgb <= '0;
      end
    end
  end

  // the window never overlaps a sync pulse so the pins stay black during either sync
  a_blank_in_sync: assert property (@(posedge clk_in) disable iff (rst)
    (!hsync_n || !vsync_n) |-> (rgb == '0));

endmodule

`default_nettype wire

/* src/vga_channel_pattern.sv */
`timescale 1ns/1ps
`default_nettype none

// chan_idx 0 is blue, 1 green, 2 red
module vga_channel_pattern #(
  parameter int chan_idx = 0
) (
  input  logic                        clk_in,
  input  logic                        rst,
  input  vga_pkg::vga_timing_t        timing,
  input  vga_pkg::vga_pattern_e       pattern,
  input  logic [vga_pkg::chan_w-1:0]  level,
  output logic [vga_pkg::chan_w-1:0]  intensity
);

  logic [vga_pkg::coord_w-1:0] bar_idx;
  logic                        cell_odd;

  assign bar_idx  = timing.x >> vga_pkg::bar_shift;
  // checker cells flip on x and on y
  assign cell_odd = timing.x[vga_pkg::check_bit] ^ timing.y[vga_pkg::check_bit];

  always_ff @(posedge clk_in) begin
    if (rst) begin
      intensity <= '0;
    end else begin
      case (pattern)
        vga_pkg::pat_solid: begin
          intensity <= level;
        end
        vga_pkg::pat_bars: begin
          // bar 7 lights every lane, so it comes out white
          intensity <= bar_idx[chan_idx] ? '1 : '0;
        end
        vga_pkg::pat_ramp: begin
          intensity <= timing.x[vga_pkg::check_bit +: vga_pkg::chan_w];
        end
        default: begin
          intensity <= cell_odd ? level : '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/vga_timing_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing_gen (
  input  logic                 clk_in,
  input  logic                 rst,
  input  vga_pkg::vga_cfg_t    cfg,
  output vga_pkg::vga_timing_t timing,
  output logic                 frame_start
);

  // geometry latched for the frame in progress
  vga_pkg::vga_axis_t          h_geom;
  vga_pkg::vga_axis_t          v_geom;
  vga_pkg::vga_phase_e         h_ph;
  vga_pkg::vga_phase_e         v_ph;
  logic [vga_pkg::coord_w-1:0] h_cnt;
  logic [vga_pkg::coord_w-1:0] v_cnt;
  logic [vga_pkg::coord_w-1:0] x;
  logic [vga_pkg::coord_w-1:0] y;
  logic                        at_start;

  vga_pkg::vga_phase_e h_nph;
  vga_pkg::vga_phase_e v_nph;
  vga_pkg::vga_phase_e h_start_ph;
  vga_pkg::vga_phase_e v_start_ph;
  logic                h_last;
  logic                v_last;
  logic                line_end;
  logic                frame_end;

  function automatic logic [vga_pkg::coord_w-1:0] phase_len(
    input vga_pkg::vga_phase_e ph,
    input vga_pkg::vga_axis_t  ax
  );
    case (ph)
      vga_pkg::ph_sync:   return ax.sync;
      vga_pkg::ph_back:   return ax.back;
      vga_pkg::ph_active: return ax.active;
      default:            return ax.front;
    endcase
  endfunction

  // next phase with a nonzero length, front wraps round to sync
  function automatic vga_pkg::vga_phase_e next_phase(
    input vga_pkg::vga_phase_e ph,
    input vga_pkg::vga_axis_t  ax
  );
    vga_pkg::vga_phase_e cand;
    vga_pkg::vga_phase_e found;
    logic                hit;
    found = ph;
    hit   = 1'b0;
    for (int i = 1; i <= 4; i++) begin
      cand = vga_pkg::vga_phase_e'(2'(ph) + 2'(i));
      if (!hit && phase_len(cand, ax) != '0) begin
        found = cand;
        hit   = 1'b1;
      end
    end
    return found;
  endfunction

  always_comb begin
    h_last     = (h_cnt == '0);
    v_last     = (v_cnt == '0);
    h_nph      = next_phase(h_ph, h_geom);
    v_nph      = next_phase(v_ph, v_geom);
    // a step that does not move forward means the axis wrapped
    line_end   = h_last && (h_nph <= h_ph);
    frame_end  = line_end && v_last && (v_nph <= v_ph);
    h_start_ph = next_phase(vga_pkg::ph_front, cfg.h);
    v_start_ph = next_phase(vga_pkg::ph_front, cfg.v);
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      h_geom   <= '0;
      v_geom   <= '0;
      h_ph     <= vga_pkg::ph_sync;
      v_ph     <= vga_pkg::ph_sync;
      h_cnt    <= '0;
      v_cnt    <= '0;
      x        <= '0;
      y        <= '0;
      at_start <= 1'b1;
    end else if (!cfg.enable || frame_end) begin
      // park at, or restart from, the first sync cycle with fresh geometry
      h_geom   <= cfg.h;
      v_geom   <= cfg.v;
      h_ph     <= h_start_ph;
      v_ph     <= v_start_ph;
      h_cnt    <= phase_len(h_start_ph, cfg.h) - 1'b1;
      v_cnt    <= phase_len(v_start_ph, cfg.v) - 1'b1;
      x        <= '0;
      y        <= '0;
      at_start <= 1'b1;
    end else begin
      at_start <= 1'b0;
      x <= (h_ph == vga_pkg::ph_active && !h_last) ? x + 1'b1 : '0;
      if (h_last) begin
        h_ph  <= h_nph;
        h_cnt <= phase_len(h_nph, h_geom) - 1'b1;
      end else begin
        h_cnt <= h_cnt - 1'b1;
      end
      // vertical moves one line per wrap of h
      if (line_end) begin
        y <= (v_ph == vga_pkg::ph_active && !v_last) ? y + 1'b1 : '0;
        if (v_last) begin
          v_ph  <= v_nph;
          v_cnt <= phase_len(v_nph, v_geom) - 1'b1;
        end else begin
          v_cnt <= v_cnt - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      timing.hsync_n <= 1'b1;
      timing.vsync_n <= 1'b1;
      timing.active  <= 1'b0;
      timing.x       <= '0;
      timing.y       <= '0;
      frame_start    <= 1'b0;
    end else begin
      timing.hsync_n <= !(cfg.enable && h_ph == vga_pkg::ph_sync);
      timing.vsync_n <= !(cfg.enable && v_ph == vga_pkg::ph_sync);
      timing.active  <= cfg.enable && h_ph == vga_pkg::ph_active && v_ph == vga_pkg::ph_active;
      timing.x       <= x;
      timing.y       <= y;
      frame_start    <= cfg.enable && at_start;
    end
  end

  a_x_in_window: assert property (@(posedge clk_in) disable iff (rst)
    timing.active |-> (timing.x < $past(h_geom.active)));

endmodule

`default_nettype wire

/* src/vga_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_apb_regs (
  input  logic              clk_in,
  input  logic              rst,
  input  logic [7:0]        paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  input  logic              frame_start,
  output vga_pkg::vga_cfg_t cfg
);

  logic [15:0] frames;
  logic        addr_hit;
  logic        access;
  logic        wr_en;

  assign access = psel && penable;
  // frame counter is read only, a write there only raises pslverr
  assign wr_en  = access && pwrite && addr_hit && (paddr != vga_pkg::addr_frames);

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access && (!addr_hit || (pwrite && paddr == vga_pkg::addr_frames));

  // read mux, also flags mapped addresses
  always_comb begin
    prdata   = '0;
    addr_hit = 1'b1;
    case (paddr)
      vga_pkg::addr_ctrl:     prdata[2:0] = {cfg.pattern, cfg.enable};
      vga_pkg::addr_color:    prdata[11:0] = cfg.color;
      vga_pkg::addr_h_sync:   prdata[vga_pkg::coord_w-1:0] = cfg.h.sync;
      vga_pkg::addr_h_back:   prdata[vga_pkg::coord_w-1:0] = cfg.h.back;
      vga_pkg::addr_h_active: prdata[vga_pkg::coord_w-1:0] = cfg.h.active;
      vga_pkg::addr_h_front:  prdata[vga_pkg::coord_w-1:0] = cfg.h.front;
      vga_pkg::addr_v_sync:   prdata[vga_pkg::coord_w-1:0] = cfg.v.sync;
      vga_pkg::addr_v_back:   prdata[vga_pkg::coord_w-1:0] = cfg.v.back;
      vga_pkg::addr_v_active: prdata[vga_pkg::coord_w-1:0] = cfg.v.active;
      vga_pkg::addr_v_front:  prdata[vga_pkg::coord_w-1:0] = cfg.v.front;
      vga_pkg::addr_frames:   prdata[15:0] = frames;
      default:                addr_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      cfg <= vga_pkg::cfg_default;
    end else if (wr_en) begin
      case (paddr)
        vga_pkg::addr_ctrl: begin
          cfg.enable  <= pwdata[0];
          cfg.pattern <= vga_pkg::vga_pattern_e'(pwdata[2:1]);
        end
        vga_pkg::addr_color:    cfg.color <= vga_pkg::vga_rgb_t'(pwdata[11:0]);
        vga_pkg::addr_h_sync:   cfg.h.sync <= pwdata[vga_pkg::coord_w-1:0];
        vga_pkg::addr_h_back:   cfg.h.back <= pwdata[vga_pkg::coord_w-1:0];
        vga_pkg::addr_h_active: cfg.h.active <= pwdata[vga_pkg::coord_w-1:0];
        vga_pkg::addr_h_front:  cfg.h.front <= pwdata[vga_pkg::coord_w-1:0];
        vga_pkg::addr_v_sync:   cfg.v.sync <= pwdata[vga_pkg::coord_w-1:0];
        vga_pkg::addr_v_back:   cfg.v.back <= pwdata[vga_pkg::coord_w-1:0];
        vga_pkg::addr_v_active: cfg.v.active <= pwdata[vga_pkg::coord_w-1:0];
        vga_pkg::addr_v_front:  cfg.v.front <= pwdata[vga_pkg::coord_w-1:0];
        default: ;
      endcase
    end
  end

  // wraps at 16 bits
  always_ff @(posedge clk_in) begin
    if (rst) begin
      frames <= '0;
    end else if (frame_start) begin
      frames <= frames + 16'd1;
    end
  end

  // with pready tied high every access phase comes straight after its setup phase
  a_setup_before_access: assert property (@(posedge clk_in) disable iff (rst)
    (psel && penable) |-> $past(psel && !penable));

endmodule

`default_nettype wire

/* src/vga_pkg.sv */
`default_nettype none

package vga_pkg;

  // widths
  localparam int coord_w   = 11;
  localparam int chan_w    = 4;
  localparam int num_chan  = 3;

  // pattern geometry, 128 pixel bars and 16 pixel checker cells
  localparam int bar_shift = 7;
  localparam int check_bit = 4;

  // register map
  localparam logic [7:0] addr_ctrl     = 8'h00;
  localparam logic [7:0] addr_color    = 8'h04;
  localparam logic [7:0] addr_h_sync   = 8'h08;
  localparam logic [7:0] addr_h_back   = 8'h0C;
  localparam logic [7:0] addr_h_active = 8'h10;
  localparam logic [7:0] addr_h_front  = 8'h14;
  localparam logic [7:0] addr_v_sync   = 8'h18;
  localparam logic [7:0] addr_v_back   = 8'h1C;
  localparam logic [7:0] addr_v_active = 8'h20;
  localparam logic [7:0] addr_v_front  = 8'h24;
  localparam logic [7:0] addr_frames   = 8'h28;

  // 640x480 defaults
  localparam logic [coord_w-1:0] h_sync_def   = 11'd96;
  localparam logic [coord_w-1:0] h_back_def   = 11'd48;
  localparam logic [coord_w-1:0] h_active_def = 11'd640;
  localparam logic [coord_w-1:0] h_front_def  = 11'd16;
  localparam logic [coord_w-1:0] v_sync_def   = 11'd2;
  localparam logic [coord_w-1:0] v_back_def   = 11'd33;
  localparam logic [coord_w-1:0] v_active_def = 11'd480;
  localparam logic [coord_w-1:0] v_front_def  = 11'd10;

  typedef enum logic [1:0] {
    pat_solid   = 2'd0,
    pat_bars    = 2'd1,
    pat_ramp    = 2'd2,
    pat_checker = 2'd3
  } vga_pattern_e;

  // order matters, the generator steps through these by increment
  typedef enum logic [1:0] {
    ph_sync   = 2'd0,
    ph_back   = 2'd1,
    ph_active = 2'd2,
    ph_front  = 2'd3
  } vga_phase_e;

  typedef struct packed {
    logic [coord_w-1:0] sync;
    logic [coord_w-1:0] back;
    logic [coord_w-1:0] active;
    logic [coord_w-1:0] front;
  } vga_axis_t;

  typedef struct packed {
    logic [chan_w-1:0] r;
    logic [chan_w-1:0] g;
    logic [chan_w-1:0] b;
  } vga_rgb_t;

  typedef struct packed {
    vga_axis_t    h;
    vga_axis_t    v;
    logic         enable;
    vga_pattern_e pattern;
    vga_rgb_t     color;
  } vga_cfg_t;

  typedef struct packed {
    logic               hsync_n;
    logic               vsync_n;
    logic               active;
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
  } vga_timing_t;

  localparam vga_cfg_t cfg_default = '{
    h: '{sync: h_sync_def, back: h_back_def, active: h_active_def, front: h_front_def},
    v: '{sync: v_sync_def, back: v_back_def, active: v_active_def, front: v_front_def},
    enable: 1'b0,
    pattern: pat_solid,
    color: '{r: '0, g: '0, b: '0}
  };

endpackage

`default_nettype wire
